// File: Makefile
TOP  := tb_default_slave
BIN  := obj_dir/V$(TOP)
SRCS := $(wildcard hw/*.sv hw/*.svh tests/*.sv)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): sources.f $(SRCS)
	verilator --binary --timing --top-module $(TOP) -f sources.f

# Pass only when the log holds the pass line
run: $(BIN)
	./$(BIN) | tee sim.log
	grep -q "^No errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: hw/axi_default_slave.sv
// AXI default slave top: write and read DECERR terminators feeding a shared error log
`include "default_slave_settings.svh"

module axi_default_slave (
    input  logic                          clk,
    input  logic                          resetn,
    // Write address channel
    input  logic                          i_aw_valid,
    output logic                          o_aw_ready,
    input  default_slave_pkg::ds_cmd_t    i_aw_cmd,
    // Write data channel
    input  logic                          i_w_valid,
    input  logic                          i_w_last,
    input  default_slave_pkg::axi_data_t  i_w_data,
    output logic                          o_w_ready,
    // Write response channel
    output logic                          o_b_valid,
    input  logic                          i_b_ready,
    output default_slave_pkg::axi_id_t    o_b_id,
    output default_slave_pkg::axi_resp_t  o_b_resp,
    // Read address channel
    input  logic                          i_ar_valid,
    output logic                          o_ar_ready,
    input  default_slave_pkg::ds_cmd_t    i_ar_cmd,
    // Read data channel
    output logic                          o_r_valid,
    output logic                          o_r_last,
    input  logic                          i_r_ready,
    output default_slave_pkg::axi_id_t    o_r_id,
    output default_slave_pkg::axi_data_t  o_r_data,
    output default_slave_pkg::axi_resp_t  o_r_resp,
    // Register port
    input  logic                          i_csr_read,
    input  logic                          i_csr_write,
    input  logic [`DS_CSR_AW-1:0]         i_csr_addr,
    input  logic [31:0]                   i_csr_wdata,
    output logic [31:0]                   o_csr_rdata,
    output logic                          o_csr_rvalid,
    output logic                          o_irq
);

    // Completion records from the terminators
    logic                           wr_done;
    default_slave_pkg::ds_log_rec_t wr_rec;
    logic                           rd_done;
    default_slave_pkg::ds_log_rec_t rd_rec;

    // ------------------------------
    // Terminators
    // ------------------------------
    write_decerr_resp u_wr (
        .clk        (clk),
        .resetn     (resetn),
        .i_aw_valid (i_aw_valid),
        .o_aw_ready (o_aw_ready),
        .i_aw_cmd   (i_aw_cmd),
        .i_w_valid  (i_w_valid),
        .i_w_last   (i_w_last),
        .i_w_data   (i_w_data),
        .o_w_ready  (o_w_ready),
        .o_b_valid  (o_b_valid),
        .i_b_ready  (i_b_ready),
        .o_b_id     (o_b_id),
        .o_b_resp   (o_b_resp),
        .o_done     (wr_done),
        .o_rec      (wr_rec)
    );

    read_decerr_resp u_rd (
        .clk        (clk),
        .resetn     (resetn),
        .i_ar_valid (i_ar_valid),
        .o_ar_ready (o_ar_ready),
        .i_ar_cmd   (i_ar_cmd),
        .o_r_valid  (o_r_valid),
        .o_r_last   (o_r_last),
        .i_r_ready  (i_r_ready),
        .o_r_id     (o_r_id),
        .o_r_data   (o_r_data),
        .o_r_resp   (o_r_resp),
        .o_done     (rd_done),
        .o_rec      (rd_rec)
    );

    // Log and interrupt
    decerr_log_csr u_log (
        .clk          (clk),
        .resetn       (resetn),
        .i_wr_done    (wr_done),
        .i_wr_rec     (wr_rec),
        .i_rd_done    (rd_done),
        .i_rd_rec     (rd_rec),
        .i_csr_read   (i_csr_read),
        .i_csr_write  (i_csr_write),
        .i_csr_addr   (i_csr_addr),
        .i_csr_wdata  (i_csr_wdata),
        .o_csr_rdata  (o_csr_rdata),
        .o_csr_rvalid (o_csr_rvalid),
        .o_irq        (o_irq)
    );

endmodule

// File: hw/decerr_log_csr.sv
// Error log: records the first unlogged DECERR transaction and serves it on the register port
`include "default_slave_settings.svh"

module decerr_log_csr (
    input  logic                           clk,
    input  logic                           resetn,
    // Completions from the terminators
    input  logic                           i_wr_done,
    input  default_slave_pkg::ds_log_rec_t i_wr_rec,
    input  logic                           i_rd_done,
    input  default_slave_pkg::ds_log_rec_t i_rd_rec,
    // Register port
    input  logic                           i_csr_read,
    input  logic                           i_csr_write,
    input  logic [`DS_CSR_AW-1:0]          i_csr_addr,
    input  logic [31:0]                    i_csr_wdata,
    output logic [31:0]                    o_csr_rdata,
    output logic                           o_csr_rvalid,
    // Interrupt
    output logic                           o_irq
);

    // Width of the packed attribute fields in the ATTR register
    localparam int ATTR_W = $bits(default_slave_pkg::axi_id_t) +
                            $bits(default_slave_pkg::axi_len_t) +
                            $bits(default_slave_pkg::axi_size_t) +
                            $bits(default_slave_pkg::axi_burst_t) +
                            $bits(default_slave_pkg::axi_prot_t);

    logic pending;
    logic irq_en;
    logic log_is_write;
    logic load;
    logic clr_pending;

    default_slave_pkg::ds_log_rec_t sel_rec;
    default_slave_pkg::ds_cmd_t     log_cmd;
    default_slave_pkg::axi_data_t   log_wdata;
    logic [31:0]                    reg_rdata;

    // ------------------------------
    // Record capture
    // ------------------------------
    // Write wins a tie, the read record is lost
    assign sel_rec = i_wr_done ? i_wr_rec : i_rd_rec;
    assign load    = ~pending & (i_wr_done | i_rd_done);

    // W1C on STATUS bit 0
    assign clr_pending = i_csr_write & (i_csr_addr == `DS_REG_STATUS) & i_csr_wdata[0];

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            pending      <= 1'b0;
            log_is_write <= 1'b0;
            irq_en       <= 1'b0;
            o_irq        <= 1'b0;
            o_csr_rvalid <= 1'b0;
        end else begin
            if (load) begin
                pending      <= 1'b1;
                log_is_write <= sel_rec.is_write;
            end else if (clr_pending) begin
                pending <= 1'b0;
            end
            if (i_csr_write & (i_csr_addr == `DS_REG_IRQ_EN)) begin
                irq_en <= i_csr_wdata[0];
            end
            o_irq        <= pending & irq_en;
            o_csr_rvalid <= i_csr_read;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            log_cmd   <= sel_rec.cmd;
            log_wdata <= sel_rec.wdata;
        end
        if (i_csr_read) begin
            o_csr_rdata <= reg_rdata;
        end
    end

    // ------------------------------
    // Register read mux
    // ------------------------------
    always_comb begin
        case (i_csr_addr)
            `DS_REG_STATUS: reg_rdata = {30'd0, log_is_write & pending, pending};
            `DS_REG_ADDR:   reg_rdata = log_cmd.addr[31:0];
            // ID in the low bits, prot on top
            `DS_REG_ATTR:   reg_rdata = {{(32 - ATTR_W){1'b0}}, log_cmd.prot, log_cmd.burst,
                                         log_cmd.size, log_cmd.len, log_cmd.id};
            `DS_REG_WDATA:  reg_rdata = log_wdata[31:0];
            `DS_REG_IRQ_EN: reg_rdata = {31'd0, irq_en};
            default:        reg_rdata = '0;
        endcase
    end

endmodule

// File: hw/default_slave_pkg.sv
// Default slave types: AXI field vectors, command and log records, FSM states
`include "default_slave_settings.svh"

package default_slave_pkg;

    // ------------------------------
    // AXI field types
    // ------------------------------
    typedef logic [`DS_ID_W-1:0]   axi_id_t;
    typedef logic [`DS_ADDR_W-1:0] axi_addr_t;
    typedef logic [`DS_DATA_W-1:0] axi_data_t;
    // Burst length minus one, AXI3 style
    typedef logic [3:0]            axi_len_t;
    typedef logic [2:0]            axi_size_t;
    typedef logic [1:0]            axi_burst_t;
    typedef logic [2:0]            axi_prot_t;
    typedef logic [1:0]            axi_resp_t;

    // Decode error response code
    localparam axi_resp_t RESP_DECERR = 2'b11;

    // Address channel payload, shared by AW and AR
    typedef struct packed {
        axi_id_t    id;
        axi_addr_t  addr;
        axi_len_t   len;
        axi_size_t  size;
        axi_burst_t burst;
        axi_prot_t  prot;
    } ds_cmd_t;

    // One terminated transaction, handed to the error log
    typedef struct packed {
        ds_cmd_t   cmd;
        axi_data_t wdata;
        logic      is_write;
    } ds_log_rec_t;

    typedef enum logic [1:0] {WR_IDLE, WR_WAIT_DATA, WR_WAIT_ADDR, WR_RESP} wr_state_e;
    typedef enum logic {RD_IDLE, RD_BEATS} rd_state_e;

endpackage

// File: hw/default_slave_settings.svh
// Default slave settings: bus widths, read fill pattern and error log register map
`ifndef DEFAULT_SLAVE_SETTINGS_SVH
`define DEFAULT_SLAVE_SETTINGS_SVH

// AXI widths
`define DS_ID_W 4
`define DS_ADDR_W 32
// Must be a multiple of 32
`define DS_DATA_W 32

// Pattern returned on every read beat, repeated across the bus
`define DS_FILL_WORD 32'hDEADBEEF

// Register port, word addressed
`define DS_CSR_AW 3
`define DS_REG_STATUS 3'd0
`define DS_REG_ADDR 3'd1
`define DS_REG_ATTR 3'd2
`define DS_REG_WDATA 3'd3
`define DS_REG_IRQ_EN 3'd4

`endif

// File: hw/read_decerr_resp.sv
// Read terminator: takes a read address and streams len+1 DECERR beats of fill data
`include "default_slave_settings.svh"

module read_decerr_resp (
    input  logic                          clk,
    input  logic                          resetn,
    // Read address channel
    input  logic                          i_ar_valid,
    output logic                          o_ar_ready,
    input  default_slave_pkg::ds_cmd_t    i_ar_cmd,
    // Read data channel
    output logic                          o_r_valid,
    output logic                          o_r_last,
    input  logic                          i_r_ready,
    output default_slave_pkg::axi_id_t    o_r_id,
    output default_slave_pkg::axi_data_t  o_r_data,
    output default_slave_pkg::axi_resp_t  o_r_resp,
    // Completion record to the error log
    output logic                          o_done,
    output default_slave_pkg::ds_log_rec_t o_rec
);

    default_slave_pkg::rd_state_e state;
    default_slave_pkg::rd_state_e next_state;

    // Beats still to send after the current one
    default_slave_pkg::axi_len_t beats_left;
    default_slave_pkg::axi_len_t beats_left_nxt;

    logic ar_hs;
    logic r_hs;

    default_slave_pkg::ds_cmd_t cmd_q;

    assign ar_hs = i_ar_valid & o_ar_ready;
    assign r_hs  = o_r_valid & i_r_ready;

    // ------------------------------
    // Beat counter and FSM
    // ------------------------------
    always_comb begin
        next_state     = state;
        beats_left_nxt = beats_left;
        if (state == default_slave_pkg::RD_IDLE) begin
            if (ar_hs) begin
                next_state     = default_slave_pkg::RD_BEATS;
                beats_left_nxt = i_ar_cmd.len;
            end
        end else if (r_hs) begin
            // Last beat accepted, burst over
            if (beats_left == '0) begin
                next_state = default_slave_pkg::RD_IDLE;
            end else begin
                beats_left_nxt = beats_left - 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state      <= default_slave_pkg::RD_IDLE;
            beats_left <= '0;
            o_ar_ready <= 1'b0;
            o_r_valid  <= 1'b0;
            o_r_last   <= 1'b0;
        end else begin
            state      <= next_state;
            beats_left <= beats_left_nxt;
            o_ar_ready <= (next_state == default_slave_pkg::RD_IDLE);
            o_r_valid  <= (next_state == default_slave_pkg::RD_BEATS);
            // Stall keeps both counter and rlast unchanged
            o_r_last   <= (next_state == default_slave_pkg::RD_BEATS) & (beats_left_nxt == '0);
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            cmd_q <= i_ar_cmd;
        end
    end

    // ------------------------------
    // Outputs
    // ------------------------------
    assign o_r_id   = cmd_q.id;
    assign o_r_data = {(`DS_DATA_W / 32){`DS_FILL_WORD}};
    assign o_r_resp = default_slave_pkg::RESP_DECERR;

    assign o_done = r_hs & o_r_last;

    // No write data on a read
    always_comb begin
        o_rec.cmd      = cmd_q;
        o_rec.wdata    = '0;
        o_rec.is_write = 1'b0;
    end

endmodule

// File: hw/write_decerr_resp.sv
// Write terminator: takes address and data in any order, answers with one DECERR response
`include "default_slave_settings.svh"

module write_decerr_resp (
    input  logic                          clk,
    input  logic                          resetn,
    // Write address channel
    input  logic                          i_aw_valid,
    output logic                          o_aw_ready,
    input  default_slave_pkg::ds_cmd_t    i_aw_cmd,
    // Write data channel
    input  logic                          i_w_valid,
    input  logic                          i_w_last,
    input  default_slave_pkg::axi_data_t  i_w_data,
    output logic                          o_w_ready,
    // Write response channel
    output logic                          o_b_valid,
    input  logic                          i_b_ready,
    output default_slave_pkg::axi_id_t    o_b_id,
    output default_slave_pkg::axi_resp_t  o_b_resp,
    // Completion record to the error log
    output logic                          o_done,
    output default_slave_pkg::ds_log_rec_t o_rec
);

    default_slave_pkg::wr_state_e state;
    default_slave_pkg::wr_state_e next_state;

    // Set once the first data beat of the burst has been captured
    logic data_flag;
    // Address phase already complete
    logic addr_flag;
    // Last data beat already taken
    logic last_flag;

    logic aw_hs;
    logic w_hs;
    logic b_hs;
    logic addr_done;
    logic data_done;

    default_slave_pkg::ds_cmd_t   cmd_q;
    default_slave_pkg::axi_data_t wdata_q;

    // ------------------------------
    // Handshakes and phase tracking
    // ------------------------------
    assign aw_hs = i_aw_valid & o_aw_ready;
    assign w_hs  = i_w_valid & o_w_ready;
    assign b_hs  = o_b_valid & i_b_ready;

    assign addr_flag = (state == default_slave_pkg::WR_WAIT_DATA);
    assign last_flag = (state == default_slave_pkg::WR_WAIT_ADDR);

    // Phase complete either earlier or at this edge
    assign addr_done = addr_flag | aw_hs;
    assign data_done = last_flag | (w_hs & i_w_last);

    always_comb begin
        next_state = state;
        if (state == default_slave_pkg::WR_RESP) begin
            // Back to idle once the master takes the response
            if (b_hs) begin
                next_state = default_slave_pkg::WR_IDLE;
            end
        end else if (addr_done & data_done) begin
            next_state = default_slave_pkg::WR_RESP;
        end else if (addr_done) begin
            next_state = default_slave_pkg::WR_WAIT_DATA;
        end else if (data_done) begin
            next_state = default_slave_pkg::WR_WAIT_ADDR;
        end
    end

    // ------------------------------
    // Control registers
    // ------------------------------
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state      <= default_slave_pkg::WR_IDLE;
            data_flag  <= 1'b0;
            o_aw_ready <= 1'b0;
            o_w_ready  <= 1'b0;
            o_b_valid  <= 1'b0;
        end else begin
            state <= next_state;
            // Cleared with the response so the next burst captures its own first beat
            if (b_hs) begin
                data_flag <= 1'b0;
            end else if (w_hs) begin
                data_flag <= 1'b1;
            end
            // Each channel stays open only until its own phase is done
            o_aw_ready <= (next_state == default_slave_pkg::WR_IDLE) |
                          (next_state == default_slave_pkg::WR_WAIT_ADDR);
            o_w_ready  <= (next_state == default_slave_pkg::WR_IDLE) |
                          (next_state == default_slave_pkg::WR_WAIT_DATA);
            o_b_valid  <= (next_state == default_slave_pkg::WR_RESP);
        end
    end

    // Command and first beat, kept for the response ID and the log
    always_ff @(posedge clk) begin
        if (aw_hs) begin
            cmd_q <= i_aw_cmd;
        end
        if (w_hs & ~data_flag) begin
            wdata_q <= i_w_data;
        end
    end

    // ------------------------------
    // Outputs
    // ------------------------------
    assign o_b_id   = cmd_q.id;
    assign o_b_resp = default_slave_pkg::RESP_DECERR;

    // Pulse in the cycle the response handshakes
    assign o_done = b_hs;

    always_comb begin
        o_rec.cmd      = cmd_q;
        o_rec.wdata    = wdata_q;
        o_rec.is_write = 1'b1;
    end

endmodule

// File: sources.f
+incdir+hw
hw/default_slave_pkg.sv
hw/write_decerr_resp.sv
hw/read_decerr_resp.sv
hw/decerr_log_csr.sv
hw/axi_default_slave.sv
tests/tb_default_slave.sv

// File: tests/tb_default_slave.sv
// Directed testbench for the default slave covering AXI writes, reads, the error log and the interrupt
`include "default_slave_settings.svh"

module tb_default_slave;

    typedef default_slave_pkg::ds_cmd_t   cmd_t;
    typedef default_slave_pkg::axi_data_t data_t;
    typedef default_slave_pkg::axi_id_t   id_t;
    typedef default_slave_pkg::axi_resp_t resp_t;

    localparam int    CLK_PERIOD = 10;
    localparam int    N_TESTS    = 6;
    // 200 cycles per test plus reset and margin
    localparam int    WATCHDOG_CYCLES = N_TESTS * 200 + 100;
    // AXI DECERR code
    localparam resp_t DECERR = 2'b11;
    // Read fill pattern, one 32-bit word of the bus
    localparam logic [31:0] FILL_WORD = 32'hDEADBEEF;

    logic clk;
    logic resetn;
    logic aw_valid;
    cmd_t aw_cmd;
    logic w_valid;
    logic w_last;
    data_t w_data;
    logic b_ready;
    logic ar_valid;
    cmd_t ar_cmd;
    logic r_ready;
    logic csr_read;
    logic csr_write;
    logic [`DS_CSR_AW-1:0] csr_addr;
    logic [31:0] csr_wdata;

    logic o_aw_ready, o_w_ready, o_b_valid, o_ar_ready, o_r_valid, o_r_last;
    id_t o_b_id, o_r_id;
    resp_t o_b_resp, o_r_resp;
    data_t o_r_data;
    logic [31:0] o_csr_rdata;
    logic o_csr_rvalid, o_irq;

    int errors = 0;
    int checks = 0;
    logic [15:0] lfsr_state = 16'd27;
    // Last write that the log should hold
    logic [31:0] logged_addr;
    logic [31:0] logged_wdata;

    axi_default_slave i_axi_default_slave (
        .clk(clk), .resetn(resetn),
        .i_aw_valid(aw_valid), .o_aw_ready(o_aw_ready), .i_aw_cmd(aw_cmd),
        .i_w_valid(w_valid), .i_w_last(w_last), .i_w_data(w_data), .o_w_ready(o_w_ready),
        .o_b_valid(o_b_valid), .i_b_ready(b_ready), .o_b_id(o_b_id), .o_b_resp(o_b_resp),
        .i_ar_valid(ar_valid), .o_ar_ready(o_ar_ready), .i_ar_cmd(ar_cmd),
        .o_r_valid(o_r_valid), .o_r_last(o_r_last), .i_r_ready(r_ready),
        .o_r_id(o_r_id), .o_r_data(o_r_data), .o_r_resp(o_r_resp),
        .i_csr_read(csr_read), .i_csr_write(csr_write), .i_csr_addr(csr_addr),
        .i_csr_wdata(csr_wdata), .o_csr_rdata(o_csr_rdata), .o_csr_rvalid(o_csr_rvalid),
        .o_irq(o_irq)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Hang guard
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired: the DUT stopped answering before the tests ended");
        $display("Errors found");
        $finish;
    end

    // ------------------------------
    // Stimulus helpers
    // ------------------------------
    // Galois LFSR stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
        end
        return v;
    endfunction

    function automatic cmd_t random_cmd(input int len);
        cmd_t c;
        c.id    = 4'(rand_bits(4));
        c.addr  = rand_bits(32);
        c.len   = 4'(len);
        c.size  = 3'd2;
        c.burst = 2'b01;
        c.prot  = 3'(rand_bits(3));
        return c;
    endfunction

    // ATTR layout with id at bit 0 and prot on top
    function automatic logic [31:0] attr_word(input cmd_t c);
        return {16'd0, c.prot, c.burst, c.size, c.len, c.id};
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic drive_aw(input cmd_t cmd);
        @(posedge clk);
        aw_cmd   <= cmd;
        aw_valid <= 1'b1;
        @(negedge clk);
        while (!o_aw_ready) @(negedge clk);
        @(posedge clk);
        aw_valid <= 1'b0;
    endtask

    task automatic drive_ar(input cmd_t cmd);
        @(posedge clk);
        ar_cmd   <= cmd;
        ar_valid <= 1'b1;
        @(negedge clk);
        while (!o_ar_ready) @(negedge clk);
        @(posedge clk);
        ar_valid <= 1'b0;
    endtask

    // Beats count up from the first data word
    task automatic drive_w(input data_t first, input int beats);
        @(posedge clk);
        for (int b = 0; b < beats; b++) begin
            w_valid <= 1'b1;
            w_data  <= first + 32'(b);
            w_last  <= (b == beats - 1);
            @(negedge clk);
            while (!o_w_ready) @(negedge clk);
            @(posedge clk);
        end
        w_valid <= 1'b0;
        w_last  <= 1'b0;
    endtask

    // Response must stay put while bready is held low
    task automatic take_bresp(input id_t exp_id, input int stall);
        @(negedge clk);
        while (!o_b_valid) @(negedge clk);
        repeat (stall + 1) begin
            check_eq(32'(o_b_id), 32'(exp_id), "bid");
            check_eq(32'(o_b_resp), 32'(DECERR), "bresp");
            @(negedge clk);
            check_eq(32'(o_b_valid), 1, "bvalid held");
        end
        @(posedge clk);
        b_ready <= 1'b1;
        @(posedge clk);
        b_ready <= 1'b0;
        @(negedge clk);
        check_eq(32'(o_b_valid), 0, "single write response");
    endtask

    task automatic read_burst(input cmd_t cmd, input bit use_stall);
        int beat;
        beat = 0;
        drive_ar(cmd);
        @(negedge clk);
        check_eq(32'(o_r_valid), 1, "rvalid after address");
        check_eq(32'(o_ar_ready), 0, "ar_ready low during burst");
        while (beat <= int'(cmd.len)) begin
            @(posedge clk);
            r_ready <= use_stall ? (rand_bits(1) != 0) : 1'b1;
            @(negedge clk);
            // A stalled beat stays on the bus
            check_eq(32'(o_r_valid), 1, "rvalid held");
            if (r_ready) begin
                for (int w = 0; w < `DS_DATA_W / 32; w++) begin
                    check_eq(o_r_data[w*32 +: 32], FILL_WORD, "rdata fill");
                end
                check_eq(32'(o_r_id), 32'(cmd.id), "rid");
                check_eq(32'(o_r_resp), 32'(DECERR), "rresp");
                check_eq(32'(o_r_last), 32'(beat == int'(cmd.len)), "rlast");
                beat++;
            end
        end
        @(posedge clk);
        r_ready <= 1'b0;
        @(negedge clk);
        check_eq(32'(o_r_valid), 0, "rvalid after last beat");
        check_eq(32'(o_ar_ready), 1, "ar_ready after last beat");
    endtask

    task automatic csr_wr(input logic [`DS_CSR_AW-1:0] addr, input logic [31:0] data);
        @(posedge clk);
        csr_write <= 1'b1;
        csr_addr  <= addr;
        csr_wdata <= data;
        @(posedge clk);
        csr_write <= 1'b0;
    endtask

    task automatic read_check(input logic [`DS_CSR_AW-1:0] addr, input logic [31:0] exp,
                              input string what);
        @(posedge clk);
        csr_read <= 1'b1;
        csr_addr <= addr;
        @(posedge clk);
        csr_read <= 1'b0;
        @(negedge clk);
        check_eq(32'(o_csr_rvalid), 1, "csr rvalid");
        check_eq(o_csr_rdata, exp, what);
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------
    task automatic write_orders();
        cmd_t cmd;
        // Address first with two beats
        cmd = random_cmd(1);
        drive_aw(cmd);
        @(negedge clk);
        check_eq(32'(o_aw_ready), 0, "aw_ready low after address");
        check_eq(32'(o_b_valid), 0, "no response before data");
        drive_w(rand_bits(32), 2);
        take_bresp(cmd.id, int'(rand_bits(2)));
        // Address and data in the same cycle
        cmd = random_cmd(0);
        fork
            drive_aw(cmd);
            drive_w(rand_bits(32), 1);
        join
        take_bresp(cmd.id, int'(rand_bits(2)));
        // Data first with three beats
        cmd = random_cmd(2);
        drive_w(rand_bits(32), 3);
        @(negedge clk);
        check_eq(32'(o_w_ready), 0, "w_ready low after last beat");
        drive_aw(cmd);
        take_bresp(cmd.id, int'(rand_bits(2)));
    endtask

    task automatic read_bursts();
        read_burst(random_cmd(int'(rand_bits(4))), 1'b0);
        repeat (3) begin
            read_burst(random_cmd(int'(rand_bits(4))), 1'b1);
        end
    endtask

    task automatic log_after_write();
        cmd_t cmd;
        data_t first;
        csr_wr(`DS_REG_STATUS, 32'h1);
        read_check(`DS_REG_STATUS, 0, "status cleared");
        cmd   = random_cmd(1);
        first = rand_bits(32);
        fork
            drive_aw(cmd);
            drive_w(first, 2);
        join
        take_bresp(cmd.id, 0);
        logged_addr  = cmd.addr;
        logged_wdata = first;
        read_check(`DS_REG_STATUS, 32'h3, "status pending write");
        read_check(`DS_REG_ADDR, cmd.addr, "logged addr");
        read_check(`DS_REG_ATTR, attr_word(cmd), "logged attr");
        read_check(`DS_REG_WDATA, first, "logged first beat");
    endtask

    task automatic log_hold_then_read();
        cmd_t cmd;
        // Pending error blocks new records
        cmd = random_cmd(0);
        drive_aw(cmd);
        drive_w(rand_bits(32), 1);
        take_bresp(cmd.id, 0);
        read_burst(random_cmd(int'(rand_bits(4))), 1'b0);
        read_check(`DS_REG_ADDR, logged_addr, "log held addr");
        read_check(`DS_REG_WDATA, logged_wdata, "log held wdata");
        // Clear so that the next read gets logged
        csr_wr(`DS_REG_STATUS, 32'h1);
        cmd = random_cmd(int'(rand_bits(4)));
        read_burst(cmd, 1'b1);
        read_check(`DS_REG_STATUS, 32'h1, "status pending read");
        read_check(`DS_REG_ADDR, cmd.addr, "read addr");
        read_check(`DS_REG_ATTR, attr_word(cmd), "read attr");
        read_check(`DS_REG_WDATA, 0, "read has no wdata");
    endtask

    task automatic irq_behavior();
        // Error still pending from the read
        repeat (3) begin
            @(negedge clk);
            check_eq(32'(o_irq), 0, "irq masked");
        end
        csr_wr(`DS_REG_IRQ_EN, 32'h1);
        repeat (2) @(negedge clk);
        check_eq(32'(o_irq), 1, "irq raised");
        read_check(`DS_REG_IRQ_EN, 1, "irq enable");
        csr_wr(`DS_REG_STATUS, 32'h1);
        repeat (2) @(negedge clk);
        check_eq(32'(o_irq), 0, "irq cleared");
    endtask

    task automatic same_cycle_finish();
        cmd_t wcmd;
        cmd_t rcmd;
        data_t wdata;
        csr_wr(`DS_REG_STATUS, 32'h1);
        wcmd  = random_cmd(0);
        rcmd  = random_cmd(0);
        wdata = rand_bits(32);
        fork
            drive_aw(wcmd);
            drive_w(wdata, 1);
            drive_ar(rcmd);
        join
        @(negedge clk);
        while (!(o_b_valid && o_r_valid)) @(negedge clk);
        check_eq(32'(o_r_last), 1, "single read beat is last");
        // Release both readies together
        @(posedge clk);
        b_ready <= 1'b1;
        r_ready <= 1'b1;
        @(posedge clk);
        b_ready <= 1'b0;
        r_ready <= 1'b0;
        @(negedge clk);
        check_eq(32'(o_b_valid), 0, "bvalid after tie");
        check_eq(32'(o_r_valid), 0, "rvalid after tie");
        read_check(`DS_REG_STATUS, 32'h3, "tie logs write");
        read_check(`DS_REG_ADDR, wcmd.addr, "tie addr");
        read_check(`DS_REG_WDATA, wdata, "tie wdata");
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        resetn    = 1'b0;
        aw_valid  = 1'b0;
        aw_cmd    = '0;
        w_valid   = 1'b0;
        w_last    = 1'b0;
        w_data    = '0;
        b_ready   = 1'b0;
        ar_valid  = 1'b0;
        ar_cmd    = '0;
        r_ready   = 1'b0;
        csr_read  = 1'b0;
        csr_write = 1'b0;
        csr_addr  = '0;
        csr_wdata = '0;
        repeat (16) @(negedge clk);
        // Quiet outputs in reset
        check_eq(32'(o_aw_ready), 0, "aw_ready in reset");
        check_eq(32'(o_w_ready), 0, "w_ready in reset");
        check_eq(32'(o_ar_ready), 0, "ar_ready in reset");
        check_eq(32'(o_irq), 0, "irq in reset");
        @(posedge clk);
        resetn <= 1'b1;
        read_check(`DS_REG_STATUS, 0, "status after reset");
        write_orders();
        read_bursts();
        log_after_write();
        log_hold_then_read();
        irq_behavior();
        same_cycle_finish();
        repeat (4) @(posedge clk);
        $display("Run complete: %0d checks, %0d failed", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
